//--- run_sim.sh
#!/usr/bin/env bash
# builds the router core testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=tb_sim
LOG_FILE=sim.log

verilator --binary --assert -f tb.f --top-module tb_p4_router_core \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if grep -q "Simulation failed" "$LOG_FILE"; then
    echo "run failed, see $LOG_FILE"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulator returned status $sim_status"
    exit 1
fi
echo "run passed"
exit 0

//--- source/forward_table.sv
////////////////////////////////////////////////////////////
// egress program id per destination bucket
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "p4_router_defines.svh"
`default_nettype none

module forward_table (
    input  var logic                                clk,
    input  var logic                                rst,
    input  var logic                                wr_en,
    input  var logic [$clog2(`P4R_FWD_ENTRIES)-1:0] wr_addr,
    input  var p4_port_pkg::port_id_t               wr_id,
    input  var logic [$clog2(`P4R_FWD_ENTRIES)-1:0] rd_addr,
    output var p4_port_pkg::port_id_t               rd_id
);

    import p4_port_pkg::*;

    port_id_t entries [`P4R_FWD_ENTRIES];

    // unprogrammed buckets forward nowhere
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `P4R_FWD_ENTRIES; i++) begin
                entries[i] <= port_id_t'(`P4R_UNKNOWN_ID);
            end
        end else if (wr_en) begin
            entries[wr_addr] <= wr_id;
        end
    end

    assign rd_id = entries[rd_addr];  // old value on same-cycle write

endmodule

`default_nettype wire

//--- source/header_pipeline.sv
////////////////////////////////////////////////////////////
// four-stage ipv4 header processing: verify, ttl, lookup,
// checksum regeneration and port mapping
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "p4_router_defines.svh"
`default_nettype none

module header_pipeline (
    input  var logic                                clk,
    input  var logic                                rst,
    input  var logic                                hdr_in_valid,
    input  var ipv4_pkg::ipv4_header_t              hdr_in,
    input  var p4_port_pkg::port_id_t               ing_port_in,
    input  var logic                                tbl_wr_en,
    input  var logic [$clog2(`P4R_FWD_ENTRIES)-1:0] tbl_wr_addr,
    input  var p4_port_pkg::port_id_t               tbl_wr_id,
    output var logic                                hdr_out_valid,
    output var ipv4_pkg::ipv4_header_t              hdr_out,
    output var p4_port_pkg::port_id_t               ing_p4_id_out,
    output var p4_port_pkg::port_id_t               egr_port_out,
    output var logic                                drop
);

    import p4_port_pkg::*;
    import ipv4_pkg::*;

    localparam int ADDR_BITS = $clog2(`P4R_FWD_ENTRIES);

    logic         s0_valid;
    ipv4_header_t s0_hdr;
    port_id_t     s0_ing_idx;
    ipv4_header_t s0_upd;
    ipv4_header_t s1_hdr;
    port_id_t     s1_ing_idx;
    logic         s1_ttl_low;
    ipv4_header_t s2_hdr;
    port_id_t     s2_ing_p4_id;
    port_id_t     s2_egr_idx;
    logic         s2_reject;
    ipv4_header_t s2_merged;
    logic         ver_rsp_valid;  // doubles as stage 1 valid
    logic         ver_ok;
    logic         gen_rsp_valid;  // doubles as stage 2 valid
    checksum_t    gen_checksum;
    port_id_t     fwd_egr_p4_id;
    port_id_t     map_ing_p4_id;
    port_id_t     map_egr_idx;

    ////////////////////////////////////////////////////////////
    // stage 0: capture, feeds the verifier

    always_ff @(posedge clk) begin
        if (rst) begin
            s0_valid <= 1'b0;
        end else begin
            s0_valid <= hdr_in_valid;
        end
    end

    always_ff @(posedge clk) begin
        s0_hdr     <= hdr_in;
        s0_ing_idx <= ing_port_in;
    end

    ipv4_checksum_verify u_verify (
        .clk         ( clk           ),
        .rst         ( rst           ),
        .req_valid   ( s0_valid      ),
        .header      ( s0_hdr        ),
        .rsp_valid   ( ver_rsp_valid ),
        .checksum_ok ( ver_ok        )
    );

    ////////////////////////////////////////////////////////////
    // stage 1: ttl update, lookup and mapping, feeds the generator

    always_comb begin
        s0_upd          = s0_hdr;
        s0_upd.ttl      = s0_hdr.ttl - 8'd1;  // wraps on 0, dropped anyway
        s0_upd.checksum = '0;
    end

    always_ff @(posedge clk) begin
        s1_hdr     <= s0_upd;
        s1_ing_idx <= s0_ing_idx;
        s1_ttl_low <= (s0_hdr.ttl < 8'd2);  // judged on the original ttl
    end

    forward_table u_forward_table (
        .clk     ( clk                           ),
        .rst     ( rst                           ),
        .wr_en   ( tbl_wr_en                     ),
        .wr_addr ( tbl_wr_addr                   ),
        .wr_id   ( tbl_wr_id                     ),
        .rd_addr ( s1_hdr.dst_addr[ADDR_BITS-1:0] ),
        .rd_id   ( fwd_egr_p4_id                 )
    );

    port_id_map u_port_id_map (
        .ing_idx   ( s1_ing_idx    ),
        .ing_p4_id ( map_ing_p4_id ),
        .egr_p4_id ( fwd_egr_p4_id ),
        .egr_idx   ( map_egr_idx   )
    );

    ipv4_checksum_gen u_gen (
        .clk       ( clk           ),
        .rst       ( rst           ),
        .req_valid ( ver_rsp_valid ),
        .header    ( s1_hdr        ),
        .rsp_valid ( gen_rsp_valid ),
        .checksum  ( gen_checksum  )
    );

    ////////////////////////////////////////////////////////////
    // stage 2: hold results until the new checksum arrives

    always_ff @(posedge clk) begin
        s2_hdr       <= s1_hdr;
        s2_ing_p4_id <= map_ing_p4_id;
        s2_egr_idx   <= map_egr_idx;
        s2_reject    <= s1_ttl_low | ~ver_ok;
    end

    always_comb begin
        s2_merged          = s2_hdr;
        s2_merged.checksum = gen_checksum;
    end

    ////////////////////////////////////////////////////////////
    // stage 3: output register

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_out_valid <= 1'b0;
            drop          <= 1'b0;
        end else begin
            hdr_out_valid <= gen_rsp_valid & ~s2_reject;
            drop          <= gen_rsp_valid & s2_reject;
        end
    end

    always_ff @(posedge clk) begin
        hdr_out       <= s2_merged;
        ing_p4_id_out <= s2_ing_p4_id;
        egr_port_out  <= s2_egr_idx;
    end

    a_out_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(hdr_out_valid && drop));

endmodule

`default_nettype wire

//--- source/ipv4_checksum_gen.sv
////////////////////////////////////////////////////////////
// ipv4 header checksum generation, one cycle latency
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ipv4_checksum_gen (
    input  var logic                   clk,
    input  var logic                   rst,
    input  var logic                   req_valid,
    input  var ipv4_pkg::ipv4_header_t header,
    output var logic                   rsp_valid,
    output var ipv4_pkg::checksum_t    checksum
);

    import ipv4_pkg::*;

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        checksum <= ~ipv4_fold_sum(header, 1'b1);  // sum of the other nine words
    end

    // upstream stage must clear the field before asking
    a_field_zeroed: assert property (@(posedge clk) disable iff (rst)
        req_valid |-> (header.checksum == '0));

endmodule

`default_nettype wire

//--- source/ipv4_checksum_verify.sv
////////////////////////////////////////////////////////////
// ipv4 header checksum check, result one cycle after request
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ipv4_checksum_verify (
    input  var logic                   clk,
    input  var logic                   rst,
    input  var logic                   req_valid,
    input  var ipv4_pkg::ipv4_header_t header,
    output var logic                   rsp_valid,
    output var logic                   checksum_ok
);

    import ipv4_pkg::*;

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= req_valid;
        end
    end

    // a good header sums to all ones, checksum word included
    always_ff @(posedge clk) begin
        checksum_ok <= (ipv4_fold_sum(header, 1'b0) == 16'hFFFF);
    end

    a_rsp_latency: assert property (@(posedge clk) disable iff (rst)
        rsp_valid == $past(req_valid));

endmodule

`default_nettype wire

//--- source/ipv4_pkg.sv
////////////////////////////////////////////////////////////
// ipv4 header layout and one's-complement checksum helpers
////////////////////////////////////////////////////////////

`include "p4_router_defines.svh"

package ipv4_pkg;

    typedef logic [15:0] checksum_t;

    // network order, first word in the msbs
    typedef struct packed {
        logic [15:0] ver_ihl_tos;
        logic [15:0] total_len;
        logic [15:0] ident;
        logic [15:0] flags_frag;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        checksum_t   checksum;
        logic [31:0] src_addr;
        logic [31:0] dst_addr;
    } ipv4_header_t;

    // folded one's-complement sum of the header words
    function automatic checksum_t ipv4_fold_sum(
        input ipv4_header_t hdr,
        input logic         skip_checksum
    );
        ipv4_header_t            h;
        logic [`P4R_HDR_BITS-1:0] raw;
        logic [19:0]             acc;
        h = hdr;
        if (skip_checksum) begin
            h.checksum = '0;  // leaves the other nine words
        end
        raw = h;
        acc = '0;
        for (int i = 0; i < `P4R_HDR_BITS / 16; i++) begin
            acc = acc + 20'(raw[i*16 +: 16]);
        end
        acc = {4'b0, acc[15:0]} + {16'b0, acc[19:16]};  // end-around carry
        acc = {4'b0, acc[15:0]} + {16'b0, acc[19:16]};
        return acc[15:0];
    endfunction

endpackage

//--- source/p4_port_pkg.sv
////////////////////////////////////////////////////////////
// port numbering: hardware indices and program port ids
////////////////////////////////////////////////////////////

`include "p4_router_defines.svh"

package p4_port_pkg;

    typedef logic [`P4R_PORT_ID_BITS-1:0] port_id_t;

    // hardware port order, shared by ingress and egress
    typedef enum logic [`P4R_PORT_ID_BITS-1:0] {
        CPU_RTL_IDX,
        OISL0_RTL_IDX,
        OISL1_RTL_IDX,
        ECP0_RTL_IDX,
        ECP1_RTL_IDX,
        HDR0_RTL_IDX,
        HDR1_RTL_IDX,
        ECG0_RTL_IDX,
        ECG1_RTL_IDX,
        ECG2_RTL_IDX,
        ECG3_RTL_IDX
    } rtl_port_e;

    localparam port_id_t CPU_P4_ID   = port_id_t'(0);
    localparam port_id_t OISL0_P4_ID = port_id_t'(20);
    localparam port_id_t OISL1_P4_ID = port_id_t'(21);
    localparam port_id_t ECP0_P4_ID  = port_id_t'(40);
    localparam port_id_t ECP1_P4_ID  = port_id_t'(41);
    localparam port_id_t HDR0_P4_ID  = port_id_t'(60);
    localparam port_id_t HDR1_P4_ID  = port_id_t'(61);
    localparam port_id_t ECG0_P4_ID  = port_id_t'(80);
    localparam port_id_t ECG1_P4_ID  = port_id_t'(81);
    localparam port_id_t ECG2_P4_ID  = port_id_t'(82);
    localparam port_id_t ECG3_P4_ID  = port_id_t'(83);

endpackage

//--- source/p4_router_core.sv
////////////////////////////////////////////////////////////
// router core top level
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "p4_router_defines.svh"
`default_nettype none

module p4_router_core (
    input  var logic                                clk,
    input  var logic                                rst,
    input  var logic                                hdr_in_valid,
    input  var ipv4_pkg::ipv4_header_t              hdr_in,
    input  var p4_port_pkg::port_id_t               ing_port_in,  // hardware index
    input  var logic                                tbl_wr_en,
    input  var logic [$clog2(`P4R_FWD_ENTRIES)-1:0] tbl_wr_addr,
    input  var p4_port_pkg::port_id_t               tbl_wr_id,    // program id
    output var logic                                hdr_out_valid,
    output var ipv4_pkg::ipv4_header_t              hdr_out,
    output var p4_port_pkg::port_id_t               ing_p4_id_out,
    output var p4_port_pkg::port_id_t               egr_port_out, // hardware index
    output var logic                                drop
);

    header_pipeline u_header_pipeline (
        .clk           ( clk           ),
        .rst           ( rst           ),
        .hdr_in_valid  ( hdr_in_valid  ),
        .hdr_in        ( hdr_in        ),
        .ing_port_in   ( ing_port_in   ),
        .tbl_wr_en     ( tbl_wr_en     ),
        .tbl_wr_addr   ( tbl_wr_addr   ),
        .tbl_wr_id     ( tbl_wr_id     ),
        .hdr_out_valid ( hdr_out_valid ),
        .hdr_out       ( hdr_out       ),
        .ing_p4_id_out ( ing_p4_id_out ),
        .egr_port_out  ( egr_port_out  ),
        .drop          ( drop          )
    );

endmodule

`default_nettype wire

//--- source/p4_router_defines.svh
////////////////////////////////////////////////////////////
// router core constants shared by the packages and RTL
////////////////////////////////////////////////////////////

`ifndef P4_ROUTER_DEFINES_SVH
`define P4_ROUTER_DEFINES_SVH

// single-beat ipv4 header, options not supported
`define P4R_HDR_BITS 160

// port ids in both numberings
`define P4R_PORT_ID_BITS 8

`define P4R_FWD_ENTRIES 16  // one entry per dst bucket

`define P4R_UNKNOWN_ID 255  // result of an unmapped id

`endif

//--- source/port_id_map.sv
////////////////////////////////////////////////////////////
// hardware index <-> program port id translation
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "p4_router_defines.svh"
`default_nettype none

module port_id_map (
    input  var p4_port_pkg::port_id_t ing_idx,
    output var p4_port_pkg::port_id_t ing_p4_id,
    input  var p4_port_pkg::port_id_t egr_p4_id,
    output var p4_port_pkg::port_id_t egr_idx
);

    import p4_port_pkg::*;

    always_comb begin
        case (ing_idx)
            CPU_RTL_IDX   : ing_p4_id = CPU_P4_ID;
            OISL0_RTL_IDX : ing_p4_id = OISL0_P4_ID;
            OISL1_RTL_IDX : ing_p4_id = OISL1_P4_ID;
            ECP0_RTL_IDX  : ing_p4_id = ECP0_P4_ID;
            ECP1_RTL_IDX  : ing_p4_id = ECP1_P4_ID;
            HDR0_RTL_IDX  : ing_p4_id = HDR0_P4_ID;
            HDR1_RTL_IDX  : ing_p4_id = HDR1_P4_ID;
            ECG0_RTL_IDX  : ing_p4_id = ECG0_P4_ID;
            ECG1_RTL_IDX  : ing_p4_id = ECG1_P4_ID;
            ECG2_RTL_IDX  : ing_p4_id = ECG2_P4_ID;
            ECG3_RTL_IDX  : ing_p4_id = ECG3_P4_ID;
            default       : ing_p4_id = port_id_t'(`P4R_UNKNOWN_ID);
        endcase
    end

    always_comb begin
        case (egr_p4_id)
            CPU_P4_ID   : egr_idx = CPU_RTL_IDX;
            OISL0_P4_ID : egr_idx = OISL0_RTL_IDX;
            OISL1_P4_ID : egr_idx = OISL1_RTL_IDX;
            ECP0_P4_ID  : egr_idx = ECP0_RTL_IDX;
            ECP1_P4_ID  : egr_idx = ECP1_RTL_IDX;
            HDR0_P4_ID  : egr_idx = HDR0_RTL_IDX;
            HDR1_P4_ID  : egr_idx = HDR1_RTL_IDX;
            ECG0_P4_ID  : egr_idx = ECG0_RTL_IDX;
            ECG1_P4_ID  : egr_idx = ECG1_RTL_IDX;
            ECG2_P4_ID  : egr_idx = ECG2_RTL_IDX;
            ECG3_P4_ID  : egr_idx = ECG3_RTL_IDX;
            default     : egr_idx = port_id_t'(`P4R_UNKNOWN_ID);  // e.g. stale table ids
        endcase
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+source
source/p4_port_pkg.sv
source/ipv4_pkg.sv
source/port_id_map.sv
source/ipv4_checksum_verify.sv
source/ipv4_checksum_gen.sv
source/forward_table.sv
source/header_pipeline.sv
source/p4_router_core.sv
testbench/tb_p4_router_core.sv

//--- testbench/tb_p4_router_core.sv
////////////////////////////////////////////////////////////
// router core testbench: random headers checked against a
// reference model by concurrent assertions
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "p4_router_defines.svh"

module tb_p4_router_core;

    import p4_port_pkg::*;
    import ipv4_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 5;
    localparam int NUM_HDRS   = 200;
    localparam int LATENCY    = 4;  // sampling edge to output strobe
    localparam int ADDR_BITS  = $clog2(`P4R_FWD_ENTRIES);
    localparam int BAD_ENTRY  = 7;  // holds an id with no port
    // worst case: every header preceded by an idle cycle
    localparam int WATCHDOG_CYCLES =
        RST_CYCLES + `P4R_FWD_ENTRIES + 2 * NUM_HDRS + 4 * LATENCY;

    // program ids in hardware index order
    localparam port_id_t PROGRAM_IDS [11] = '{8'd0, 8'd20, 8'd21, 8'd40, 8'd41,
        8'd60, 8'd61, 8'd80, 8'd81, 8'd82, 8'd83};

    logic                 clk;
    logic                 rst;
    logic                 hdr_in_valid;
    ipv4_header_t         hdr_in;
    port_id_t             ing_port_in;
    logic                 tbl_wr_en;
    logic [ADDR_BITS-1:0] tbl_wr_addr;
    port_id_t             tbl_wr_id;
    logic                 hdr_out_valid;
    ipv4_header_t         hdr_out;
    port_id_t             ing_p4_id_out;
    port_id_t             egr_port_out;
    logic                 drop;

    // model results, driven alongside the inputs
    logic                 exp_valid;
    logic                 exp_drop;
    ipv4_header_t         exp_hdr;
    port_id_t             exp_ing_id;
    port_id_t             exp_egr;
    port_id_t             tbl_model [`P4R_FWD_ENTRIES];
    logic                 out_sum_ok;
    logic                 input_seen = 1'b0;
    integer               seed;
    int                   pass_count = 0;
    int                   drop_count = 0;
    int                   unknown_ing_count = 0;
    int                   unknown_egr_count = 0;
    int                   ttl_low_sent = 0;
    int                   bad_sum_sent = 0;
    int                   max_burst = 0;

    p4_router_core u_p4_router_core (
        .clk           ( clk           ),
        .rst           ( rst           ),
        .hdr_in_valid  ( hdr_in_valid  ),
        .hdr_in        ( hdr_in        ),
        .ing_port_in   ( ing_port_in   ),
        .tbl_wr_en     ( tbl_wr_en     ),
        .tbl_wr_addr   ( tbl_wr_addr   ),
        .tbl_wr_id     ( tbl_wr_id     ),
        .hdr_out_valid ( hdr_out_valid ),
        .hdr_out       ( hdr_out       ),
        .ing_p4_id_out ( ing_p4_id_out ),
        .egr_port_out  ( egr_port_out  ),
        .drop          ( drop          )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // reference model helpers

    function automatic logic [15:0] ones_sum(input logic [`P4R_HDR_BITS-1:0] bits);
        logic [31:0] acc;
        acc = '0;
        for (int i = 0; i < 10; i++) begin
            acc = acc + {16'd0, bits[i*16 +: 16]};
        end
        while (acc[31:16] != 16'd0) begin
            acc = {16'd0, acc[15:0]} + {16'd0, acc[31:16]};  // end-around carry
        end
        return acc[15:0];
    endfunction

    function automatic port_id_t program_id_of(input port_id_t idx);
        port_id_t id;
        id = port_id_t'(`P4R_UNKNOWN_ID);
        for (int i = 0; i < 11; i++) begin
            if (idx == port_id_t'(i)) begin
                id = PROGRAM_IDS[i];
            end
        end
        return id;
    endfunction

    function automatic port_id_t rtl_index_of(input port_id_t id);
        port_id_t idx;
        idx = port_id_t'(`P4R_UNKNOWN_ID);
        for (int i = 0; i < 11; i++) begin
            if (PROGRAM_IDS[i] == id) begin
                idx = port_id_t'(i);
            end
        end
        return idx;
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic value_error(input string msg);
        abort_run($sformatf("[ERROR] at %0d ns: %s", $time, msg));
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus

    task automatic load_table();
        port_id_t id;
        for (int i = 0; i < `P4R_FWD_ENTRIES; i++) begin
            id = (i == BAD_ENTRY) ? port_id_t'(99) : PROGRAM_IDS[i % 11];
            @(posedge clk);
            tbl_wr_en    <= 1'b1;
            tbl_wr_addr  <= ADDR_BITS'(i);
            tbl_wr_id    <= id;
            tbl_model[i] = id;
        end
        @(posedge clk);
        tbl_wr_en <= 1'b0;
    endtask

    task automatic send_header();
        ipv4_header_t h;
        ipv4_header_t e;
        logic [31:0]  rnd;
        logic [3:0]   ing;
        rnd           = $random(seed);
        h.ver_ihl_tos = {8'h45, rnd[7:0]};
        h.protocol    = rnd[15:8];
        h.ttl         = rnd[23:16];
        ing           = rnd[27:24];  // 11 to 15 have no program id
        case (rnd[30:28])
            3'd0:    h.ttl = 8'd0;
            3'd1:    h.ttl = 8'd1;
            default: ;
        endcase
        rnd          = $random(seed);
        h.total_len  = rnd[15:0];
        h.ident      = rnd[31:16];
        rnd          = $random(seed);
        h.flags_frag = rnd[15:0];
        h.src_addr   = $random(seed);
        h.dst_addr   = $random(seed);
        h.checksum   = '0;
        h.checksum   = ~ones_sum(h);
        rnd          = $random(seed);
        if (rnd[2:0] == 3'd0) begin
            h.checksum   = h.checksum ^ (16'd1 << rnd[7:4]);  // single bit error
            bad_sum_sent = bad_sum_sent + 1;
        end
        if (h.ttl < 8'd2) begin
            ttl_low_sent = ttl_low_sent + 1;
        end
        e            = h;
        e.ttl        = h.ttl - 8'd1;
        e.checksum   = '0;
        e.checksum   = ~ones_sum(e);
        hdr_in_valid <= 1'b1;
        hdr_in       <= h;
        ing_port_in  <= {4'd0, ing};
        exp_valid    <= 1'b1;
        exp_drop     <= (ones_sum(h) != 16'hFFFF) || (h.ttl < 8'd2);
        exp_hdr      <= e;
        exp_ing_id   <= program_id_of({4'd0, ing});
        exp_egr      <= rtl_index_of(tbl_model[h.dst_addr[ADDR_BITS-1:0]]);
    endtask

    initial begin
        logic [31:0] gap_rnd;
        int          burst;
        seed         = 32'ha89a;
        rst          = 1'b1;
        hdr_in_valid = 1'b0;
        hdr_in       = '0;
        ing_port_in  = '0;
        tbl_wr_en    = 1'b0;
        tbl_wr_addr  = '0;
        tbl_wr_id    = '0;
        exp_valid    = 1'b0;
        exp_drop     = 1'b0;
        exp_hdr      = '0;
        exp_ing_id   = '0;
        exp_egr      = '0;
        burst        = 0;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        load_table();
        for (int n = 0; n < NUM_HDRS; n++) begin
            @(posedge clk);
            gap_rnd = $random(seed);
            if (gap_rnd[1:0] == 2'd0) begin  // idle cycle between bursts
                hdr_in_valid <= 1'b0;
                exp_valid    <= 1'b0;
                burst        = 0;
                @(posedge clk);
            end
            send_header();
            burst     = burst + 1;
            max_burst = (burst > max_burst) ? burst : max_burst;
        end
        @(posedge clk);
        hdr_in_valid <= 1'b0;
        exp_valid    <= 1'b0;
        while (pass_count + drop_count < NUM_HDRS) begin
            @(posedge clk);
        end
        repeat (LATENCY) @(posedge clk);  // no stray strobe after the last header
        if (drop_count > 0 && pass_count > 0 && unknown_ing_count > 0 &&
            unknown_egr_count > 0 && ttl_low_sent > 0 && bad_sum_sent > 0 &&
            max_burst >= LATENCY) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            abort_run("random stimulus missed a case: drop, unknown id or long burst");
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run($sformatf("watchdog expired with %0d of %0d headers out",
            pass_count + drop_count, NUM_HDRS));
    end

    ////////////////////////////////////////////////////////////
    // output monitor and checks

    assign out_sum_ok = (ones_sum(hdr_out) == 16'hFFFF);

    always @(posedge clk) begin
        if (hdr_in_valid) begin
            input_seen <= 1'b1;
        end
        if (!rst) begin
            if (hdr_out_valid) begin
                pass_count <= pass_count + 1;
            end
            if (drop) begin
                drop_count <= drop_count + 1;
            end
            if ((hdr_out_valid || drop) && ing_p4_id_out == port_id_t'(`P4R_UNKNOWN_ID)) begin
                unknown_ing_count <= unknown_ing_count + 1;
            end
            if (hdr_out_valid && egr_port_out == port_id_t'(`P4R_UNKNOWN_ID)) begin
                unknown_egr_count <= unknown_egr_count + 1;
            end
        end
    end

    a_quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
        !input_seen |-> !(hdr_out_valid || drop))
        else value_error("output strobe before the first header");

    a_strobe_timing: assert property (@(posedge clk) disable iff (rst)
        (hdr_out_valid || drop) == $past(exp_valid, LATENCY))
        else value_error("output strobe does not follow the input by 4 cycles");

    a_drop_decision: assert property (@(posedge clk) disable iff (rst)
        (hdr_out_valid || drop) |-> (drop == $past(exp_drop, LATENCY)))
        else value_error($sformatf("drop is %0b, model disagrees", drop));

    a_header_value: assert property (@(posedge clk) disable iff (rst)
        hdr_out_valid |-> (hdr_out == $past(exp_hdr, LATENCY)))
        else value_error($sformatf("header %h differs from model", hdr_out));

    a_checksum_verifies: assert property (@(posedge clk) disable iff (rst)
        hdr_out_valid |-> out_sum_ok)
        else value_error("output header checksum does not sum to all ones");

    a_ingress_id: assert property (@(posedge clk) disable iff (rst)
        (hdr_out_valid || drop) |-> (ing_p4_id_out == $past(exp_ing_id, LATENCY)))
        else value_error($sformatf("ingress id %0d differs from model", ing_p4_id_out));

    a_egress_port: assert property (@(posedge clk) disable iff (rst)
        hdr_out_valid |-> (egr_port_out == $past(exp_egr, LATENCY)))
        else value_error($sformatf("egress port %0d differs from model", egr_port_out));

endmodule
